/* Bender.yml */
package:
  name: async_fifo

sources:
  # packages
  - common/fifo_cfg_pkg.sv
  - common/fifo_types_pkg.sv
  # rtl
  - source/fifo_ram.sv
  - fifo_ctrl/fifo_wr_ctrl.sv
  - fifo_ctrl/fifo_rd_ctrl.sv
  - source/async_fifo.sv
  # testbench
  - target: simulation
    files:
      - tests/async_fifo_tb.sv

/* async_fifo.f */
common/fifo_cfg_pkg.sv
common/fifo_types_pkg.sv
source/fifo_ram.sv
fifo_ctrl/fifo_wr_ctrl.sv
fifo_ctrl/fifo_rd_ctrl.sv
source/async_fifo.sv
tests/async_fifo_tb.sv

/* common/fifo_cfg_pkg.sv */
package fifo_cfg_pkg;

  // data path
  localparam int unsigned data_width = 8;

  // storage size, must stay a power of two for the gray pointers
  localparam int unsigned fifo_depth = 16;
  localparam int unsigned addr_width = $clog2(fifo_depth);

  // almost flag thresholds, in words of occupancy
  localparam int unsigned afull_level  = 14; // afull at or above
  localparam int unsigned aempty_level = 2;  // aempty at or below

endpackage

/* common/fifo_types_pkg.sv */
package fifo_types_pkg;

  import fifo_cfg_pkg::*;

  // one stored word
  typedef logic [data_width-1:0] data_t;

  // ram address, low bits of a pointer
  typedef logic [addr_width-1:0] addr_t;

  // pointer with wrap bit, binary or gray, also used for occupancy
  typedef logic [addr_width:0] ptr_t;

endpackage

/* fifo_ctrl/fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module fifo_rd_ctrl
  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;
(
  input  logic  rd_clk,
  input  logic  wr_rst_n,
  input  logic  rd_en,
  input  ptr_t  wr_ptr_gray,
  output logic  rd_accept,
  output addr_t rd_addr,
  output ptr_t  rd_ptr_gray,
  output logic  empty,
  output logic  aempty
);

  ptr_t rd_bin;       // binary read pointer
  ptr_t rd_bin_nxt;
  ptr_t rd_gray_nxt;

  ptr_t wr_gray_s1;   // write pointer synchronizer
  ptr_t wr_gray_s2;
  ptr_t wr_bin_sync;  // synchronized write pointer, binary

  ptr_t used_nxt;     // occupancy as seen from the read side
  logic empty_nxt;
  logic aempty_nxt;

  // reads while empty do nothing
  assign rd_accept = rd_en & ~empty;

  assign rd_bin_nxt  = rd_bin + ptr_t'(rd_accept);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;
  assign rd_addr     = rd_bin[addr_width-1:0]; // oldest word

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_bin      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_ptr_gray; // crosses from wr_clk
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_comb begin
    wr_bin_sync[addr_width] = wr_gray_s2[addr_width];
    for (int i = addr_width - 1; i >= 0; i--) begin
      wr_bin_sync[i] = wr_bin_sync[i+1] ^ wr_gray_s2[i];
    end
  end

  // empty once the next read pointer catches up with the write pointer
  assign empty_nxt = (rd_gray_nxt == wr_gray_s2);

  assign used_nxt   = wr_bin_sync - rd_bin_nxt;
  assign aempty_nxt = (used_nxt <= ptr_t'(aempty_level));

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

/* fifo_ctrl/fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module fifo_wr_ctrl
  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;
(
  input  logic  wr_clk,
  input  logic  wr_rst_n,
  input  logic  wr_en,
  input  ptr_t  rd_ptr_gray,
  output logic  wr_accept,
  output addr_t wr_addr,
  output ptr_t  wr_ptr_gray,
  output logic  full,
  output logic  afull
);

  ptr_t wr_bin;       // binary write pointer
  ptr_t wr_bin_nxt;
  ptr_t wr_gray_nxt;

  ptr_t rd_gray_s1;   // read pointer synchronizer
  ptr_t rd_gray_s2;
  ptr_t rd_bin_sync;  // synchronized read pointer, binary

  ptr_t used_nxt;     // occupancy as seen from the write side
  logic full_nxt;
  logic afull_nxt;

  // writes while full are dropped
  assign wr_accept = wr_en & ~full;

  assign wr_bin_nxt  = wr_bin + ptr_t'(wr_accept);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;
  assign wr_addr     = wr_bin[addr_width-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_ptr_gray <= wr_gray_nxt; // one bit changes per edge
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_ptr_gray; // crosses from rd_clk
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // gray to binary, msb down
  always_comb begin
    rd_bin_sync[addr_width] = rd_gray_s2[addr_width];
    for (int i = addr_width - 1; i >= 0; i--) begin
      rd_bin_sync[i] = rd_bin_sync[i+1] ^ rd_gray_s2[i];
    end
  end

  // full when write leads read by exactly one lap
  assign full_nxt = (wr_gray_nxt ==
                     {~rd_gray_s2[addr_width -: 2], rd_gray_s2[addr_width-2:0]});

  assign used_nxt  = wr_bin_nxt - rd_bin_sync;
  assign afull_nxt = (used_nxt >= ptr_t'(afull_level));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

/* source/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo
  import fifo_types_pkg::*;
(
  input  logic  wr_clk,
  input  logic  wr_rst_n,
  input  logic  wr_en,
  input  data_t wr_data,
  input  logic  rd_clk,
  input  logic  rd_en,
  output data_t rd_data,
  output logic  full,
  output logic  afull,
  output logic  empty,
  output logic  aempty
);

  logic  wr_accept;
  addr_t wr_addr;
  ptr_t  wr_ptr_gray; // to the rd_clk domain

  logic  rd_accept;
  addr_t rd_addr;
  ptr_t  rd_ptr_gray; // to the wr_clk domain

  fifo_wr_ctrl i_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_accept   (wr_accept),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  fifo_rd_ctrl i_rd_ctrl (
    .rd_clk      (rd_clk),
    .wr_rst_n    (wr_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_accept   (rd_accept),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  // storage, written and read only on accepted transfers
  fifo_ram i_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_accept),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_en    (rd_accept),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

/* source/fifo_ram.sv */
`timescale 1ns/1ps

module fifo_ram
  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;
(
  input  logic  wr_clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  logic  rd_clk,
  input  logic  wr_rst_n,
  input  logic  rd_en,
  input  addr_t rd_addr,
  output data_t rd_data
);

  data_t mem [fifo_depth];

  // write port, wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, rd_clk domain
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr]; // holds when no read
    end
  end

endmodule

/* tests/async_fifo_tb.sv */
`timescale 1ns/1ps

module async_fifo_tb
  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;
();

  localparam int wr_period_ps   = 11000;
  localparam int rd_period_ps   = 8000;
  localparam int reset_cycles   = 8;            // rd_clk cycles
  localparam int fill_cycles    = fifo_depth + 8; // wr_en held past full
  localparam int step_wr_gap    = 7;            // one write and then idle
  localparam int step_rd_gap    = 9;            // one read and then idle
  localparam int rand_cycles    = 400;          // wr_clk cycles of random traffic
  localparam int rand_rd_cycles = (rand_cycles * wr_period_ps) / rd_period_ps;
  // a read can leave full high for up to 3 wr_clk edges or about 5 rd_clk cycles
  localparam int full_read_window = 6;

  localparam int wr_cycles_total = fill_cycles + 6 + fifo_depth * step_wr_gap + rand_cycles + 8;
  localparam int rd_cycles_total = 3 * fifo_depth + fifo_depth * step_rd_gap + 4 * fifo_depth + 16;
  localparam int plan_rd_cycles  = reset_cycles + rd_cycles_total +
                                   (wr_cycles_total * wr_period_ps) / rd_period_ps;
  localparam int timeout_cycles  = 2 * plan_rd_cycles;

  logic  wr_clk;
  logic  rd_clk;
  logic  wr_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  rd_en;
  data_t rd_data;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  data_t       model[$];            // reference contents with the oldest first
  data_t       exp_rd_data;
  logic        exp_full;
  logic        exp_empty;
  logic [full_read_window-1:0] rd_hist; // accepted reads with the newest in bit 0
  realtime     last_wr_time;
  realtime     last_rd_time;
  int          cycle_count;
  logic [31:0] lfsr_state;

  async_fifo i_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #(rd_period_ps / 2000.0) rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #(wr_period_ps / 2000.0) wr_clk = ~wr_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    fail_run($sformatf("mismatch at time %0t: %s expected %0h, actual %0h",
                       $time, name, expected, actual));
  endtask

  // taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic wait_wr(input int n);
    repeat (n) @(posedge wr_clk);
  endtask

  task automatic wait_rd(input int n);
    repeat (n) @(posedge rd_clk);
  endtask

  task automatic write_burst(input int n, input data_t base);
    for (int i = 0; i < n; i++) begin
      @(posedge wr_clk);
      #1;
      wr_en   = 1'b1;
      wr_data = data_t'(base + i);
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic read_burst(input int n);
    @(posedge rd_clk);
    #1;
    rd_en = 1'b1;
    wait_rd(n);
    #1;
    rd_en = 1'b0;
  endtask

  // mostly writes in the first half, mostly idle in the second
  task automatic write_random(input int n);
    logic [1:0] b;
    for (int i = 0; i < n; i++) begin
      @(posedge wr_clk);
      #1;
      b       = 2'(lfsr_bits(2));
      wr_en   = (i < n / 2) ? (b[0] | b[1]) : (b[0] & b[1]);
      wr_data = data_t'(lfsr_bits(data_width));
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic read_random(input int n);
    logic [1:0] b;
    for (int i = 0; i < n; i++) begin
      @(posedge rd_clk);
      #1;
      b     = 2'(lfsr_bits(2));
      rd_en = (i < n / 2) ? (b[0] & b[1]) : (b[0] | b[1]);
    end
    @(posedge rd_clk);
    #1;
    rd_en = 1'b0;
  endtask

  // write side checks and model push on pre-edge values
  always @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      assert (!full && !afull) else fail_run("full or afull set during reset");
    end else begin
      if (exp_full) begin
        assert (full) else report_mismatch("full", 1, full);
      end
      if (full) begin
        assert (model.size() + $countones(rd_hist) >= fifo_depth)
          else fail_run("full is high while the FIFO has free entries not explained by sync lag");
      end
      if ($realtime - last_rd_time > 4 * wr_period_ps / 1000.0) begin
        assert (afull == (model.size() >= afull_level))
          else report_mismatch("afull", model.size() >= afull_level, afull);
      end
      exp_full = 1'b0;
      if (wr_en && !full) begin
        assert (model.size() < fifo_depth)
          else fail_run("write accepted while the FIFO already holds fifo_depth words");
        model.push_back(wr_data);
        last_wr_time = $realtime;
        exp_full     = (model.size() == fifo_depth);
      end
    end
  end

  // read side checks with model pop and run limit
  always @(posedge rd_clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      fail_run("timeout, the run did not finish within the cycle limit");
    end else if (!wr_rst_n) begin
      assert (empty && aempty && !full && !afull && rd_data == '0)
        else fail_run("flags or rd_data not at reset values during reset");
    end else begin
      assert (rd_data == exp_rd_data) else report_mismatch("rd_data", exp_rd_data, rd_data);
      if (exp_empty) begin
        assert (empty) else report_mismatch("empty", 1, empty);
      end
      if (!empty) begin
        assert (model.size() > 0) else fail_run("empty is low while the model queue is empty");
      end
      if ($realtime - last_wr_time > 4 * rd_period_ps / 1000.0) begin
        assert (aempty == (model.size() <= aempty_level))
          else report_mismatch("aempty", model.size() <= aempty_level, aempty);
      end
      exp_empty = 1'b0;
      rd_hist   = {rd_hist[full_read_window-2:0], 1'b0};
      if (rd_en && !empty) begin
        exp_rd_data  = model.pop_front();
        rd_hist[0]   = 1'b1;
        last_rd_time = $realtime;
        exp_empty    = (model.size() == 0);
      end
    end
  end

  initial begin
    lfsr_state   = 32'h7fdc;
    wr_rst_n     = 1'b1;
    wr_en        = 1'b0;
    wr_data      = '0;
    rd_en        = 1'b0;
    exp_rd_data  = '0;
    exp_full     = 1'b0;
    exp_empty    = 1'b0;
    rd_hist      = '0;
    last_wr_time = 0.0;
    last_rd_time = 0.0;
    cycle_count  = 0;

    #1;
    wr_rst_n = 1'b0;
    wait_rd(reset_cycles);
    #1;
    wr_rst_n = 1'b1;
    @(posedge rd_clk);
    #1;
    assert (!full && !afull && empty && aempty && rd_data == '0)
      else fail_run("flags or rd_data not at reset values one cycle after reset release");

    // overflow with reads stalled
    write_burst(fill_cycles, 8'h00);
    wait_wr(4);
    assert (model.size() == fifo_depth)
      else report_mismatch("model count", fifo_depth, model.size());

    // underflow with rd_en held well past the last word
    read_burst(3 * fifo_depth);
    assert (model.size() == 0 && empty) else fail_run("FIFO not empty after the drain");

    // stepped fill and drain for the almost flags
    wait_rd(8);
    for (int lvl = 0; lvl < fifo_depth; lvl++) begin
      write_burst(1, data_t'(8'h40 + lvl));
      wait_wr(step_wr_gap - 1);
    end
    for (int lvl = 0; lvl < fifo_depth; lvl++) begin
      read_burst(1);
      wait_rd(step_rd_gap - 1);
    end

    fork
      write_random(rand_cycles);
      read_random(rand_rd_cycles);
    join

    wait_wr(4);
    @(posedge rd_clk);
    #1;
    rd_en = 1'b1;
    do begin
      @(posedge rd_clk);
      #1;
    end while (model.size() != 0 || !empty);
    rd_en = 1'b0;
    wait_rd(4);

    $display("TEST PASSED");
    $finish;
  end

endmodule
